// File: list.f
+incdir+logic
logic/uce_pkg.sv
logic/uce_req_decode.sv
logic/uce_engine.sv
logic/uce_resp_unit.sv
logic/uce_top.sv
tb/uce_clk_gen.sv
tb/uce_sva.sv
tb/uce_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= uce_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := sim passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/uce_tb.sv
// testbench for the uncached-and-miss engine with cache and memory models
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_tb
  import uce_pkg::*;
();

  localparam int RANDOM_REQS     = 40;
  localparam int TOTAL_REQS      = 1 + 2 + 2 + 4 + 5 + RANDOM_REQS;
  localparam int CYCLES_PER_REQ  = 40;
  localparam int WATCHDOG_MARGIN = 4;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * CYCLES_PER_REQ * WATCHDOG_MARGIN;

  typedef logic [135:0] chk_t;

  logic      clk_i;
  logic      reset_i;
  logic      cache_req_v_i;
  req_kind_e cache_req_type_i;
  paddr_t    cache_req_addr_i;
  msg_size_t cache_req_size_i;
  dword_t    cache_req_data_i;
  logic      cache_req_yumi_o;
  logic      cache_req_busy_o;
  logic      cache_req_complete_o;
  logic      cache_req_credits_full_o;
  logic      cache_req_credits_empty_o;
  logic      tag_mem_v_o;
  tag_op_e   tag_mem_op_o;
  index_t    tag_mem_index_o;
  ctag_t     tag_mem_tag_o;
  logic      tag_mem_yumi_i;
  logic      data_mem_v_o;
  data_op_e  data_mem_op_o;
  index_t    data_mem_index_o;
  block_t    data_mem_data_o;
  logic      data_mem_yumi_i;
  logic      mem_fwd_v_o;
  mem_type_e mem_fwd_type_o;
  paddr_t    mem_fwd_addr_o;
  msg_size_t mem_fwd_size_o;
  dword_t    mem_fwd_data_o;
  logic      mem_fwd_ready_and_i;
  logic      mem_rev_v_i;
  mem_type_e mem_rev_type_i;
  paddr_t    mem_rev_addr_i;
  block_t    mem_rev_data_i;
  logic      mem_rev_ready_and_o;

  // predicted traffic, {type, addr, size, data}, {op, index, tag}, {op, index, data}
  logic [100:0] exp_fwd_q[$];
  logic [28:0]  exp_tag_q[$];
  logic [132:0] exp_data_q[$];
  // memory requests waiting for a response, {type, addr}
  logic [33:0]  mem_q[$];
  logic [100:0] fwd_exp;
  logic [28:0]  tag_exp;
  logic [132:0] data_exp;
  logic [33:0]  rev_item;

  int errors;
  int test_err_start;
  int tests_run;
  int tests_failed;
  int complete_exp;
  int complete_seen;
  int fwd_count;
  int ready_pct;
  int ack_tokens;
  bit hold_acks;
  bit rev_taken;
  bit quiet;

  uce_clk_gen clk_gen_i (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  uce_top uce_top_i (.*);

  function automatic bit chance(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  // each 32-bit word is the address with its word number folded into the top bits
  function automatic block_t mem_block(input paddr_t addr);
    block_t blk;
    for (int i = 0; i < `UCE_BLOCK_WIDTH / 32; i++)
      blk[i*32 +: 32] = addr ^ (32'(i) << 28);
    return blk;
  endfunction

  task automatic check_value(input chk_t actual, input chk_t expected, input string what);
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic predict_req(input req_kind_e kind, input paddr_t addr,
                             input msg_size_t size, input dword_t data);
    paddr_t blk_addr;
    block_t blk;
    blk_addr = {addr[31:4], 4'h0};
    blk      = mem_block(addr);
    case (kind)
      e_req_miss_load:
      begin
        exp_fwd_q.push_back({e_mem_rd, blk_addr, 3'd4, 64'h0});
        exp_tag_q.push_back({e_tag_set, addr[7:4], addr[31:8]});
        exp_data_q.push_back({e_data_write, addr[7:4], mem_block(blk_addr)});
        complete_exp++;
      end
      e_req_uc_load:
      begin
        exp_fwd_q.push_back({e_mem_uc_rd, addr, size, 64'h0});
        exp_data_q.push_back({e_data_uncached, addr[7:4], {2{blk[63:0]}}});
        complete_exp++;
      end
      e_req_uc_store:
        exp_fwd_q.push_back({e_mem_uc_wr, addr, size, data});
      default:
      begin
        for (int i = 0; i < `UCE_SETS; i++)
          exp_tag_q.push_back({e_tag_clear, 4'(i), 24'h0});
        complete_exp++;
      end
    endcase
  endtask

  // leaves the request valid, so a call is followed by another one or by release_req
  task automatic issue_req(input req_kind_e kind, input paddr_t addr,
                           input msg_size_t size, input dword_t data);
    @(posedge clk_i);
    cache_req_v_i    <= 1'b1;
    cache_req_type_i <= kind;
    cache_req_addr_i <= addr;
    cache_req_size_i <= size;
    cache_req_data_i <= data;
    predict_req(kind, addr, size, data);
    do
      @(negedge clk_i);
    while (!cache_req_yumi_o);
  endtask

  task automatic release_req();
    @(posedge clk_i);
    cache_req_v_i <= 1'b0;
  endtask

  task automatic wait_quiet();
    do
      @(posedge clk_i);
    while (!quiet);
  endtask

  task automatic wait_fwd_count(input int target);
    while (fwd_count < target)
      @(posedge clk_i);
  endtask

  task automatic end_test(input string name);
    check_value(chk_t'(complete_seen), chk_t'(complete_exp), "complete pulse count");
    tests_run++;
    if (errors == test_err_start)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  task automatic test_reset_sweep();
    // the sweep ends with a complete pulse, the engine is ready one cycle later
    do
      @(negedge clk_i);
    while (!cache_req_complete_o);
    @(negedge clk_i);
    check_value(chk_t'(cache_req_busy_o), chk_t'(1'b0), "busy after sweep");
    wait_quiet();
    end_test("reset sweep");
  endtask

  task automatic test_miss_load();
    issue_req(e_req_miss_load, 32'h1234_5678, 3'd0, 64'h0);
    issue_req(e_req_miss_load, 32'hABCD_00F3, 3'd0, 64'h0);
    release_req();
    wait_quiet();
    end_test("miss load");
  endtask

  task automatic test_uc_load();
    issue_req(e_req_uc_load, 32'h8000_1004, 3'd2, 64'h0);
    issue_req(e_req_uc_load, 32'h0000_0FF8, 3'd3, 64'h0);
    release_req();
    wait_quiet();
    end_test("uncached load");
  endtask

  task automatic test_uc_stores();
    issue_req(e_req_uc_store, 32'h4000_0000, 3'd3, 64'h0123_4567_89AB_CDEF);
    issue_req(e_req_uc_store, 32'h4000_0008, 3'd2, 64'h0000_0000_DEAD_BEEF);
    issue_req(e_req_uc_store, 32'h4000_0011, 3'd0, 64'h0000_0000_0000_005A);
    issue_req(e_req_uc_store, 32'h4000_0102, 3'd1, 64'h0000_0000_0000_C0DE);
    release_req();
    wait_quiet();
    @(negedge clk_i);
    check_value(chk_t'(cache_req_credits_empty_o), chk_t'(1'b1), "credits empty after acks");
    end_test("uncached stores");
  endtask

  task automatic test_credit_limit();
    int start;
    start = fwd_count;
    @(negedge clk_i);
    hold_acks  = 1'b1;
    ack_tokens = 0;
    for (int i = 0; i < `UCE_MAX_CREDITS; i++)
      issue_req(e_req_uc_store, 32'h5000_0000 + 32'(i * 8), 3'd3, {32'hFACE_0000, 32'(i)});
    release_req();
    wait_fwd_count(start + `UCE_MAX_CREDITS);
    @(negedge clk_i);
    check_value(chk_t'(cache_req_credits_full_o), chk_t'(1'b1), "credits full");
    check_value(chk_t'(cache_req_busy_o), chk_t'(1'b1), "busy while credits full");
    issue_req(e_req_uc_store, 32'h5000_0100, 3'd3, 64'h5555_AAAA_5555_AAAA);
    release_req();
    repeat (8) @(posedge clk_i);
    check_value(chk_t'(fwd_count), chk_t'(start + `UCE_MAX_CREDITS), "forwards while full");
    @(negedge clk_i);
    ack_tokens = 1;
    wait_fwd_count(start + `UCE_MAX_CREDITS + 1);
    @(negedge clk_i);
    hold_acks = 1'b0;
    wait_quiet();
    end_test("credit limit");
  endtask

  task automatic test_random_mix();
    int        pick;
    req_kind_e kind;
    @(negedge clk_i);
    ready_pct = 60;
    for (int i = 0; i < RANDOM_REQS; i++)
    begin
      pick = int'($urandom % 8);
      if (pick < 3)
        kind = e_req_miss_load;
      else if (pick < 5)
        kind = e_req_uc_load;
      else if (pick < 7)
        kind = e_req_uc_store;
      else
        kind = e_req_clear;
      issue_req(kind, $urandom, msg_size_t'($urandom % 4), {$urandom, $urandom});
    end
    release_req();
    wait_quiet();
    @(negedge clk_i);
    ready_pct = 100;
    end_test("random mix");
  endtask

  // handshakes are judged at the falling edge, where every input and output is settled
  always @(negedge clk_i)
  begin
    rev_taken = mem_rev_v_i && mem_rev_ready_and_o;
    if (!reset_i)
    begin
      if (mem_fwd_v_o && mem_fwd_ready_and_i)
      begin
        if (exp_fwd_q.size() == 0)
        begin
          errors++;
          $display("unexpected memory forward at %0t to address %0h", $time, mem_fwd_addr_o);
        end
        else
        begin
          fwd_exp = exp_fwd_q.pop_front();
          check_value(chk_t'(mem_fwd_type_o), chk_t'(fwd_exp[100:99]), "forward type");
          check_value(chk_t'(mem_fwd_addr_o), chk_t'(fwd_exp[98:67]), "forward address");
          check_value(chk_t'(mem_fwd_size_o), chk_t'(fwd_exp[66:64]), "forward size");
          if (fwd_exp[100:99] == e_mem_uc_wr)
            check_value(chk_t'(mem_fwd_data_o), chk_t'(fwd_exp[63:0]), "store data");
        end
        mem_q.push_back({mem_fwd_type_o, mem_fwd_addr_o});
        fwd_count++;
      end
      if (tag_mem_v_o && tag_mem_yumi_i)
      begin
        if (exp_tag_q.size() == 0)
        begin
          errors++;
          $display("unexpected tag packet at %0t for index %0d", $time, tag_mem_index_o);
        end
        else
        begin
          tag_exp = exp_tag_q.pop_front();
          check_value(chk_t'(tag_mem_op_o), chk_t'(tag_exp[28]), "tag op");
          check_value(chk_t'(tag_mem_index_o), chk_t'(tag_exp[27:24]), "tag index");
          check_value(chk_t'(tag_mem_tag_o), chk_t'(tag_exp[23:0]), "tag value");
          if (tag_exp[28] == e_tag_clear)
            check_value(chk_t'(cache_req_busy_o), chk_t'(1'b1), "busy during clear");
        end
      end
      if (data_mem_v_o && data_mem_yumi_i)
      begin
        if (exp_data_q.size() == 0)
        begin
          errors++;
          $display("unexpected data packet at %0t", $time);
        end
        else
        begin
          data_exp = exp_data_q.pop_front();
          check_value(chk_t'(data_mem_op_o), chk_t'(data_exp[132]), "data op");
          if (data_exp[132] == e_data_write)
            check_value(chk_t'(data_mem_index_o), chk_t'(data_exp[131:128]), "data index");
          check_value(chk_t'(data_mem_data_o), chk_t'(data_exp[127:0]), "data value");
        end
      end
      if (cache_req_complete_o)
        complete_seen++;
    end
    quiet = !reset_i && exp_fwd_q.size() == 0 && exp_tag_q.size() == 0
            && exp_data_q.size() == 0 && mem_q.size() == 0 && !mem_rev_v_i
            && !cache_req_busy_o;
  end

  // memory and packet sinks, answering in order with optional held acks
  always @(posedge clk_i)
  begin
    mem_fwd_ready_and_i <= chance(ready_pct);
    tag_mem_yumi_i      <= chance(ready_pct);
    data_mem_yumi_i     <= chance(ready_pct);
    if (!mem_rev_v_i || rev_taken)
    begin
      mem_rev_v_i <= 1'b0;
      if (mem_q.size() > 0 && chance(ready_pct))
      begin
        rev_item = mem_q[0];
        if (!(hold_acks && rev_item[33:32] == e_mem_uc_wr && ack_tokens == 0))
        begin
          void'(mem_q.pop_front());
          if (hold_acks && rev_item[33:32] == e_mem_uc_wr)
            ack_tokens--;
          mem_rev_v_i    <= 1'b1;
          mem_rev_type_i <= mem_type_e'(rev_item[33:32]);
          mem_rev_addr_i <= rev_item[31:0];
          mem_rev_data_i <= (rev_item[33:32] == e_mem_uc_wr) ? '0 : mem_block(rev_item[31:0]);
        end
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h3156));
    cache_req_v_i       = 1'b0;
    cache_req_type_i    = e_req_miss_load;
    cache_req_addr_i    = '0;
    cache_req_size_i    = '0;
    cache_req_data_i    = '0;
    tag_mem_yumi_i      = 1'b0;
    data_mem_yumi_i     = 1'b0;
    mem_fwd_ready_and_i = 1'b0;
    mem_rev_v_i         = 1'b0;
    mem_rev_type_i      = e_mem_rd;
    mem_rev_addr_i      = '0;
    mem_rev_data_i      = '0;
    ready_pct           = 100;
    hold_acks           = 1'b0;
    ack_tokens          = 0;
    // the sweep after reset is a clear without a request
    predict_req(e_req_clear, '0, '0, '0);

    test_reset_sweep();
    test_miss_load();
    test_uc_load();
    test_uc_stores();
    test_credit_limit();
    test_random_mix();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: tb/uce_sva.sv
// engine protocol assertions for credits, valid stability and store completion
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_sva
  import uce_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input logic      credits_full_i,
  input logic      complete_i,
  input logic      tag_v_i,
  input tag_op_e   tag_op_i,
  input index_t    tag_index_i,
  input ctag_t     tag_tag_i,
  input logic      tag_yumi_i,
  input logic      data_v_i,
  input data_op_e  data_op_i,
  input index_t    data_index_i,
  input block_t    data_data_i,
  input logic      data_yumi_i,
  input logic      fwd_v_i,
  input mem_type_e fwd_type_i,
  input paddr_t    fwd_addr_i,
  input msg_size_t fwd_size_i,
  input dword_t    fwd_data_i,
  input logic      fwd_ready_i
);

  fwd_credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_full_i |-> !fwd_v_i)
    else $error("memory forward valid while credits are full");

  tag_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_v_i && !tag_yumi_i |=> tag_v_i && $stable({tag_op_i, tag_index_i, tag_tag_i}))
    else $error("tag packet changed before it was taken");

  data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_i && !data_yumi_i |=> data_v_i && $stable({data_op_i, data_index_i, data_data_i}))
    else $error("data packet changed before it was taken");

  fwd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_v_i && !fwd_ready_i |=>
      fwd_v_i && $stable({fwd_type_i, fwd_addr_i, fwd_size_i, fwd_data_i}))
    else $error("memory forward changed before it was sent");

  // stores retire without a complete pulse
  store_silent: assert property (@(posedge clk_i) disable iff (reset_i)
    !(complete_i && fwd_v_i && fwd_ready_i && fwd_type_i == e_mem_uc_wr))
    else $error("complete pulsed on a store forward");

endmodule

bind uce_engine uce_sva engine_sva_i (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .credits_full_i (credits_full_i),
  .complete_i     (cache_req_complete_o),
  .tag_v_i        (tag_mem_v_o),
  .tag_op_i       (tag_mem_op_o),
  .tag_index_i    (tag_mem_index_o),
  .tag_tag_i      (tag_mem_tag_o),
  .tag_yumi_i     (tag_mem_yumi_i),
  .data_v_i       (data_mem_v_o),
  .data_op_i      (data_mem_op_o),
  .data_index_i   (data_mem_index_o),
  .data_data_i    (data_mem_data_o),
  .data_yumi_i    (data_mem_yumi_i),
  .fwd_v_i        (mem_fwd_v_o),
  .fwd_type_i     (mem_fwd_type_o),
  .fwd_addr_i     (mem_fwd_addr_o),
  .fwd_size_i     (mem_fwd_size_o),
  .fwd_data_i     (mem_fwd_data_o),
  .fwd_ready_i    (mem_fwd_ready_and_i)
);

// File: tb/uce_clk_gen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps

module uce_clk_gen
#(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
)
(
  output logic clk_o,
  output logic reset_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: logic/uce_top.sv
// uncached-and-miss engine top, joins decode, engine and response unit
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_top
  import uce_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      cache_req_v_i,
  input  req_kind_e cache_req_type_i,
  input  paddr_t    cache_req_addr_i,
  input  msg_size_t cache_req_size_i,
  input  dword_t    cache_req_data_i,
  output logic      cache_req_yumi_o,
  output logic      cache_req_busy_o,
  output logic      cache_req_complete_o,
  output logic      cache_req_credits_full_o,
  output logic      cache_req_credits_empty_o,

  output logic      tag_mem_v_o,
  output tag_op_e   tag_mem_op_o,
  output index_t    tag_mem_index_o,
  output ctag_t     tag_mem_tag_o,
  input  logic      tag_mem_yumi_i,

  output logic      data_mem_v_o,
  output data_op_e  data_mem_op_o,
  output index_t    data_mem_index_o,
  output block_t    data_mem_data_o,
  input  logic      data_mem_yumi_i,

  output logic      mem_fwd_v_o,
  output mem_type_e mem_fwd_type_o,
  output paddr_t    mem_fwd_addr_o,
  output msg_size_t mem_fwd_size_o,
  output dword_t    mem_fwd_data_o,
  input  logic      mem_fwd_ready_and_i,

  input  logic      mem_rev_v_i,
  input  mem_type_e mem_rev_type_i,
  input  paddr_t    mem_rev_addr_i,
  input  block_t    mem_rev_data_i,
  output logic      mem_rev_ready_and_o
);

  logic      req_v, req_ready, req_done;
  req_kind_e req_kind;
  paddr_t    req_addr;
  msg_size_t req_size;
  dword_t    req_data;

  logic      fill_v, fill_yumi;
  paddr_t    fill_addr;
  block_t    fill_data;

  uce_req_decode decode_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cache_req_v_i    (cache_req_v_i),
    .cache_req_type_i (cache_req_type_i),
    .cache_req_addr_i (cache_req_addr_i),
    .cache_req_size_i (cache_req_size_i),
    .cache_req_data_i (cache_req_data_i),
    .cache_req_yumi_o (cache_req_yumi_o),
    .req_ready_i      (req_ready),
    .req_done_i       (req_done),
    .req_v_o          (req_v),
    .req_kind_o       (req_kind),
    .req_addr_o       (req_addr),
    .req_size_o       (req_size),
    .req_data_o       (req_data)
  );

  uce_engine engine_i (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .req_v_i              (req_v),
    .req_kind_i           (req_kind),
    .req_addr_i           (req_addr),
    .req_size_i           (req_size),
    .req_data_i           (req_data),
    .req_ready_o          (req_ready),
    .req_done_o           (req_done),
    .fill_v_i             (fill_v),
    .fill_addr_i          (fill_addr),
    .fill_data_i          (fill_data),
    .fill_yumi_o          (fill_yumi),
    .credits_full_i       (cache_req_credits_full_o),
    .cache_req_busy_o     (cache_req_busy_o),
    .cache_req_complete_o (cache_req_complete_o),
    .tag_mem_v_o          (tag_mem_v_o),
    .tag_mem_op_o         (tag_mem_op_o),
    .tag_mem_index_o      (tag_mem_index_o),
    .tag_mem_tag_o        (tag_mem_tag_o),
    .tag_mem_yumi_i       (tag_mem_yumi_i),
    .data_mem_v_o         (data_mem_v_o),
    .data_mem_op_o        (data_mem_op_o),
    .data_mem_index_o     (data_mem_index_o),
    .data_mem_data_o      (data_mem_data_o),
    .data_mem_yumi_i      (data_mem_yumi_i),
    .mem_fwd_v_o          (mem_fwd_v_o),
    .mem_fwd_type_o       (mem_fwd_type_o),
    .mem_fwd_addr_o       (mem_fwd_addr_o),
    .mem_fwd_size_o       (mem_fwd_size_o),
    .mem_fwd_data_o       (mem_fwd_data_o),
    .mem_fwd_ready_and_i  (mem_fwd_ready_and_i)
  );

  uce_resp_unit resp_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .mem_rev_v_i         (mem_rev_v_i),
    .mem_rev_type_i      (mem_rev_type_i),
    .mem_rev_addr_i      (mem_rev_addr_i),
    .mem_rev_data_i      (mem_rev_data_i),
    .mem_rev_ready_and_o (mem_rev_ready_and_o),
    .mem_fwd_v_i         (mem_fwd_v_o),
    .mem_fwd_ready_and_i (mem_fwd_ready_and_i),
    .fill_v_o            (fill_v),
    .fill_addr_o         (fill_addr),
    .fill_data_o         (fill_data),
    .fill_yumi_i         (fill_yumi),
    .credits_full_o      (cache_req_credits_full_o),
    .credits_empty_o     (cache_req_credits_empty_o)
  );

endmodule

// File: logic/uce_resp_unit.sv
// memory response buffer with write ack filter and outstanding message credits
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_resp_unit
  import uce_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      mem_rev_v_i,
  input  mem_type_e mem_rev_type_i,
  input  paddr_t    mem_rev_addr_i,
  input  block_t    mem_rev_data_i,
  output logic      mem_rev_ready_and_o,

  input  logic      mem_fwd_v_i,
  input  logic      mem_fwd_ready_and_i,

  output logic      fill_v_o,
  output paddr_t    fill_addr_o,
  output block_t    fill_data_o,
  input  logic      fill_yumi_i,

  output logic      credits_full_o,
  output logic      credits_empty_o
);

  logic        buf_v_r;
  mem_type_e   buf_type_r;
  credit_cnt_t credit_cnt_r;

  wire buf_ack = (buf_type_r == e_mem_uc_wr);
  // acks leave on their own, everything else waits for the engine
  wire buf_deq = buf_v_r & (buf_ack | fill_yumi_i);
  wire buf_enq = mem_rev_v_i & mem_rev_ready_and_o;
  wire fwd_xfer = mem_fwd_v_i & mem_fwd_ready_and_i;

  assign mem_rev_ready_and_o = ~buf_v_r | buf_deq;
  assign fill_v_o            = buf_v_r & ~buf_ack;

  assign credits_full_o  = (credit_cnt_r == credit_cnt_t'(`UCE_MAX_CREDITS));
  assign credits_empty_o = (credit_cnt_r == '0);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      buf_v_r      <= 1'b0;
      credit_cnt_r <= '0;
    end
    else
    begin
      if (buf_enq)
        buf_v_r <= 1'b1;
      else if (buf_deq)
        buf_v_r <= 1'b0;
      credit_cnt_r <= credit_cnt_r + credit_cnt_t'(fwd_xfer) - credit_cnt_t'(buf_deq);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (buf_enq)
    begin
      buf_type_r  <= mem_rev_type_i;
      fill_addr_o <= mem_rev_addr_i;
      fill_data_o <= mem_rev_data_i;
    end
  end

endmodule

// File: logic/uce_engine.sv
// engine FSM, sweeps sets, issues memory messages and writes tag and data packets
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_engine
  import uce_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      req_v_i,
  input  req_kind_e req_kind_i,
  input  paddr_t    req_addr_i,
  input  msg_size_t req_size_i,
  input  dword_t    req_data_i,
  output logic      req_ready_o,
  output logic      req_done_o,

  input  logic      fill_v_i,
  input  paddr_t    fill_addr_i,
  input  block_t    fill_data_i,
  output logic      fill_yumi_o,
  input  logic      credits_full_i,

  output logic      cache_req_busy_o,
  output logic      cache_req_complete_o,

  output logic      tag_mem_v_o,
  output tag_op_e   tag_mem_op_o,
  output index_t    tag_mem_index_o,
  output ctag_t     tag_mem_tag_o,
  input  logic      tag_mem_yumi_i,

  output logic      data_mem_v_o,
  output data_op_e  data_mem_op_o,
  output index_t    data_mem_index_o,
  output block_t    data_mem_data_o,
  input  logic      data_mem_yumi_i,

  output logic      mem_fwd_v_o,
  output mem_type_e mem_fwd_type_o,
  output paddr_t    mem_fwd_addr_o,
  output msg_size_t mem_fwd_size_o,
  output dword_t    mem_fwd_data_o,
  input  logic      mem_fwd_ready_and_i
);

  uce_state_e state_r, state_n;
  index_t     index_cnt_r;
  logic       index_up;
  logic       tag_sent_r, data_sent_r;
  logic       fwd_done;
  logic       store_send;

  wire index_last = (index_cnt_r == index_t'(`UCE_SETS - 1));

  wire index_t fill_index = fill_addr_i[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
  wire ctag_t  fill_tag   =
    fill_addr_i[`UCE_BLOCK_OFFSET_WIDTH + `UCE_INDEX_WIDTH +: `UCE_CTAG_WIDTH];

  wire paddr_t block_addr =
    {req_addr_i[`UCE_PADDR_WIDTH-1:`UCE_BLOCK_OFFSET_WIDTH], {`UCE_BLOCK_OFFSET_WIDTH{1'b0}}};

  assign req_ready_o      = (state_r == e_ready);
  assign cache_req_busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full_i;
  assign store_send       = req_ready_o & req_v_i & (req_kind_i == e_req_uc_store);
  assign fwd_done         = mem_fwd_v_o & mem_fwd_ready_and_i;

  // stores retire silently
  assign cache_req_complete_o = req_done_o & ~store_send;

  always_comb
  begin
    state_n          = state_r;
    index_up         = 1'b0;
    req_done_o       = 1'b0;
    fill_yumi_o      = 1'b0;

    tag_mem_v_o      = 1'b0;
    tag_mem_op_o     = e_tag_set;
    tag_mem_index_o  = fill_index;
    tag_mem_tag_o    = fill_tag;

    data_mem_v_o     = 1'b0;
    data_mem_op_o    = e_data_write;
    data_mem_index_o = fill_index;
    data_mem_data_o  = fill_data_i;

    mem_fwd_v_o      = 1'b0;
    mem_fwd_type_o   = e_mem_rd;
    mem_fwd_addr_o   = block_addr;
    mem_fwd_size_o   = msg_size_t'(`UCE_BLOCK_OFFSET_WIDTH);
    mem_fwd_data_o   = '0;

    unique case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_mem_v_o     = 1'b1;
        tag_mem_op_o    = e_tag_clear;
        tag_mem_index_o = index_cnt_r;
        tag_mem_tag_o   = '0;
        index_up        = tag_mem_yumi_i;
        req_done_o      = index_up & index_last;
        if (req_done_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        if (req_v_i)
        begin
          unique case (req_kind_i)
            e_req_uc_store:
            begin
              // sent straight from ready, the ack is never waited for
              mem_fwd_v_o    = ~credits_full_i;
              mem_fwd_type_o = e_mem_uc_wr;
              mem_fwd_addr_o = req_addr_i;
              mem_fwd_size_o = req_size_i;
              mem_fwd_data_o = req_data_i;
              req_done_o     = fwd_done;
            end
            e_req_clear:
              state_n = e_clear;
            default:
              state_n = e_send;
          endcase
        end
      end
      e_send:
      begin
        mem_fwd_v_o = ~credits_full_i;
        if (req_kind_i != e_req_miss_load)
        begin
          mem_fwd_type_o = e_mem_uc_rd;
          mem_fwd_addr_o = req_addr_i;
          mem_fwd_size_o = req_size_i;
        end
        if (fwd_done)
          state_n = (req_kind_i == e_req_miss_load) ? e_read_wait : e_uc_read_wait;
      end
      e_read_wait:
      begin
        // each packet drops once taken, the line is done when both are in
        tag_mem_v_o  = fill_v_i & ~tag_sent_r;
        data_mem_v_o = fill_v_i & ~data_sent_r;
        fill_yumi_o  = fill_v_i & (tag_sent_r | tag_mem_yumi_i)
                       & (data_sent_r | data_mem_yumi_i);
        req_done_o   = fill_yumi_o;
        if (req_done_o)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_mem_v_o    = fill_v_i;
        data_mem_op_o   = e_data_uncached;
        data_mem_data_o =
          {(`UCE_BLOCK_WIDTH / `UCE_DWORD_WIDTH){fill_data_i[0 +: `UCE_DWORD_WIDTH]}};
        fill_yumi_o     = data_mem_v_o & data_mem_yumi_i;
        req_done_o      = fill_yumi_o;
        if (req_done_o)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r     <= e_reset;
      index_cnt_r <= '0;
      tag_sent_r  <= 1'b0;
      data_sent_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      // wraps to zero after the last set
      if (index_up)
        index_cnt_r <= index_cnt_r + index_t'(1);
      if (fill_yumi_o)
      begin
        tag_sent_r  <= 1'b0;
        data_sent_r <= 1'b0;
      end
      else if (state_r == e_read_wait)
      begin
        tag_sent_r  <= tag_sent_r | (tag_mem_v_o & tag_mem_yumi_i);
        data_sent_r <= data_sent_r | (data_mem_v_o & data_mem_yumi_i);
      end
    end
  end

endmodule

// File: logic/uce_req_decode.sv
// request decode, accepts one cache request and holds it until the engine is done
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_req_decode
  import uce_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      cache_req_v_i,
  input  req_kind_e cache_req_type_i,
  input  paddr_t    cache_req_addr_i,
  input  msg_size_t cache_req_size_i,
  input  dword_t    cache_req_data_i,
  output logic      cache_req_yumi_o,

  input  logic      req_ready_i,
  input  logic      req_done_i,
  output logic      req_v_o,
  output req_kind_e req_kind_o,
  output paddr_t    req_addr_o,
  output msg_size_t req_size_o,
  output dword_t    req_data_o
);

  // a new request may replace one that finishes this cycle
  assign cache_req_yumi_o = cache_req_v_i & req_ready_i & (~req_v_o | req_done_i);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      req_v_o <= 1'b0;
    else if (cache_req_yumi_o)
      req_v_o <= 1'b1;
    else if (req_done_i)
      req_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_o)
    begin
      req_kind_o <= cache_req_type_i;
      req_addr_o <= cache_req_addr_i;
      req_size_o <= cache_req_size_i;
      req_data_o <= cache_req_data_i;
    end
  end

endmodule

// File: logic/uce_pkg.sv
// uncached-and-miss engine shared vector types and encodings
`include "uce_config.svh"

package uce_pkg;

  typedef logic [`UCE_PADDR_WIDTH-1:0]        paddr_t;
  typedef logic [`UCE_INDEX_WIDTH-1:0]        index_t;
  typedef logic [`UCE_CTAG_WIDTH-1:0]         ctag_t;
  typedef logic [`UCE_BLOCK_WIDTH-1:0]        block_t;
  typedef logic [`UCE_DWORD_WIDTH-1:0]        dword_t;
  typedef logic [`UCE_MSG_SIZE_WIDTH-1:0]     msg_size_t;
  typedef logic [`UCE_CREDIT_WIDTH-1:0]       credit_cnt_t;

  typedef enum logic [1:0] {
    e_req_miss_load = 2'd0,
    e_req_uc_load   = 2'd1,
    e_req_uc_store  = 2'd2,
    e_req_clear     = 2'd3
  } req_kind_e;

  // memory responses carry the type of the message they answer
  typedef enum logic [1:0] {
    e_mem_rd    = 2'd0,
    e_mem_uc_rd = 2'd1,
    e_mem_uc_wr = 2'd2
  } mem_type_e;

  typedef enum logic {
    e_tag_clear = 1'b0,
    e_tag_set   = 1'b1
  } tag_op_e;

  typedef enum logic {
    e_data_write    = 1'b0,
    e_data_uncached = 1'b1
  } data_op_e;

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_ready,
    e_send,
    e_read_wait,
    e_uc_read_wait
  } uce_state_e;

endpackage

// File: logic/uce_config.svh
// uncached-and-miss engine widths, depths and derived field widths
`ifndef UCE_CONFIG_SVH
`define UCE_CONFIG_SVH

`define UCE_PADDR_WIDTH 32
`define UCE_BLOCK_WIDTH 128
`define UCE_DWORD_WIDTH 64
`define UCE_SETS 16
`define UCE_MAX_CREDITS 4

// derived from the values above
`define UCE_INDEX_WIDTH 4
// log2 of bytes per block, also the block read size code
`define UCE_BLOCK_OFFSET_WIDTH 4
`define UCE_CTAG_WIDTH (`UCE_PADDR_WIDTH - `UCE_INDEX_WIDTH - `UCE_BLOCK_OFFSET_WIDTH)
`define UCE_CREDIT_WIDTH 3

`define UCE_MSG_SIZE_WIDTH 3

`endif
